//--- Makefile
VERILATOR ?= verilator
TOP       ?= ctrl_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- common/ctrl_pkg.sv
// Shared types and constants of the CPU controller; imported by every RTL module and the testbench

package ctrl_pkg;

    // ============================================================
    // Data widths
    // ============================================================

    // Instruction or extension word
    typedef logic [15:0] word_t;

    // Displacement or bus address
    typedef logic [31:0] long_t;

    // Data register number D0..D7
    typedef logic [2:0]  reg_sel_t;

    localparam int NUM_DREGS = 8;

    // Branch target is relative to the word after the opcode
    localparam long_t BRA_WORD_STEP = 32'd2;

    // Low byte of BIW_0 that selects the 16-bit branch form
    localparam logic [7:0] DISPL_WORD_CODE = 8'h00;

    // ============================================================
    // Opcodes and state machines
    // ============================================================

    // Opcode as delivered by the external decoder
    typedef enum logic [2:0] {
        OP_MOVEQ       = 3'd0,
        OP_ADD_MEM     = 3'd1,
        OP_MOVE_TO_MEM = 3'd2,
        OP_BRA         = 3'd3,
        OP_ILLEGAL     = 3'd4
    } op_t;

    // Fetch side of the stage
    typedef enum logic [2:0] {
        START_OP      = 3'd0,
        FETCH_EXWORD  = 3'd1,
        FETCH_OPERAND = 3'd2,
        INIT_EXEC_WB  = 3'd3
    } fetch_state_t;

    // Execute and writeback side of the stage
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        EXECUTE    = 2'd1,
        WRITEBACK  = 2'd2,
        WRITE_DEST = 2'd3
    } exec_state_t;

endpackage

//--- exec/exec_wb_fsm.sv
// Execute and writeback FSM; waits for the ALU, then writes a data register or requests a store
`timescale 1ns/1ns

module exec_wb_fsm (
    input  logic               CLK,
    input  logic               RESET_CPU,
    input  logic               alu_init,
    input  ctrl_pkg::op_t      op,
    input  ctrl_pkg::word_t    biw_0,
    input  ctrl_pkg::long_t    op_adr,
    input  logic               alu_bsy,
    input  logic               wr_done,
    input  logic               bus_err,
    output logic               exec_idle,
    output ctrl_pkg::op_t      op_wb,
    output ctrl_pkg::reg_sel_t dr_sel_wr,
    output logic               mark_used,
    output logic               dr_wr,
    output logic               wr_req,
    output ctrl_pkg::long_t    wr_adr
);
    import ctrl_pkg::*;

    exec_state_t state;
    exec_state_t next_state;

    // ============================================================
    // Writeback buffer
    // ============================================================

    // Captured at ALU start so fetch may move on
    always_ff @(posedge CLK) begin
        if (alu_init) begin
            op_wb     <= op;
            dr_sel_wr <= biw_0[11:9];
            wr_adr    <= op_adr;
        end
    end

    // Mark Dn once the buffered register number is visible
    always_ff @(posedge CLK) begin
        if (RESET_CPU) begin
            mark_used <= 1'b0;
        end else begin
            mark_used <= alu_init && (op != OP_MOVE_TO_MEM);
        end
    end

    // ============================================================
    // State machine
    // ============================================================

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (alu_init) begin
                    next_state = EXECUTE;
                end
            end
            EXECUTE: begin
                // Result ready when the ALU is no longer busy
                if (!alu_bsy) begin
                    next_state = (op_wb == OP_MOVE_TO_MEM) ? WRITE_DEST : WRITEBACK;
                end
            end
            WRITEBACK: next_state = IDLE;
            WRITE_DEST: begin
                if (wr_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
        if (bus_err) begin
            next_state = IDLE;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET_CPU) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign exec_idle = (state == IDLE);

    // Register write lasts exactly one cycle
    assign dr_wr = (state == WRITEBACK);

    // Store request held until the bus cycle completes
    assign wr_req = (state == WRITE_DEST);

endmodule

//--- fetch/branch_displacement.sv
// Registered branch displacement of BRA; 8-bit or 16-bit form, sign extended plus the word step
`timescale 1ns/1ns

module branch_displacement (
    input  logic            CLK,
    input  ctrl_pkg::word_t biw_0,
    input  ctrl_pkg::word_t biw_1,
    output ctrl_pkg::long_t displacement
);
    import ctrl_pkg::*;

    long_t displ_ext;

    // Zero byte in BIW_0 selects the word displacement in BIW_1
    always_comb begin
        if (biw_0[7:0] == DISPL_WORD_CODE) begin
            displ_ext = {{16{biw_1[15]}}, biw_1};
        end else begin
            displ_ext = {{24{biw_0[7]}}, biw_0[7:0]};
        end
    end

    // Valid in the cycle after the opcode is taken
    always_ff @(posedge CLK) begin
        displacement <= displ_ext + BRA_WORD_STEP;
    end

endmodule

//--- fetch/fetch_fsm.sv
// Fetch FSM of the controller stage; takes operation words, fetches extension words and operands
`timescale 1ns/1ns

module fetch_fsm (
    input  logic               CLK,
    input  logic               RESET_CPU,
    input  logic               opd_ack,
    input  ctrl_pkg::op_t      op,
    input  ctrl_pkg::word_t    biw_0,
    input  logic               ew_ack,
    input  ctrl_pkg::word_t    ext_word,
    input  logic               rd_done,
    input  logic               bus_err,
    input  logic               dr_in_use,
    input  logic               exec_idle,
    output logic               ow_req,
    output logic               ew_req,
    output logic               rd_req,
    output ctrl_pkg::long_t    op_adr,
    output ctrl_pkg::reg_sel_t dr_sel_rd,
    output logic               alu_init,
    output logic               pc_add_displ,
    output logic               ipipe_flush,
    output logic               trap_illegal
);
    import ctrl_pkg::*;

    fetch_state_t state;
    fetch_state_t next_state;

    // Word ready flags
    logic ow_rdy;
    logic ow_rdy_nxt;
    logic ew_rdy;

    // Hazard detection
    logic uses_dreg;
    logic stall;
    logic ow_take;

    // ============================================================
    // Hazard check in START_OP
    // ============================================================

    // Dn field is source and destination for all register opcodes
    assign dr_sel_rd = biw_0[11:9];

    assign uses_dreg = (op == OP_MOVEQ) || (op == OP_ADD_MEM) || (op == OP_MOVE_TO_MEM);

    // Hold the word while exec is busy or its Dn awaits writeback
    assign stall = !exec_idle || (uses_dreg && dr_in_use);

    assign ow_take = (state == START_OP) && ow_rdy && !stall;

    // ============================================================
    // Next state
    // ============================================================

    always_comb begin
        next_state = state;
        case (state)
            START_OP: begin
                if (ow_take) begin
                    case (op)
                        OP_MOVEQ:       next_state = INIT_EXEC_WB;
                        OP_ADD_MEM:     next_state = FETCH_EXWORD;
                        OP_MOVE_TO_MEM: next_state = FETCH_EXWORD;
                        // BRA and ILLEGAL finish here with a strobe
                        default:        next_state = START_OP;
                    endcase
                end
            end
            FETCH_EXWORD: begin
                if (ew_rdy) begin
                    // Only ADD_MEM reads memory before the ALU starts
                    next_state = (op == OP_ADD_MEM) ? FETCH_OPERAND : INIT_EXEC_WB;
                end
            end
            FETCH_OPERAND: begin
                if (rd_done) begin
                    next_state = INIT_EXEC_WB;
                end
            end
            INIT_EXEC_WB: begin
                if (exec_idle) begin
                    next_state = START_OP;
                end
            end
            default: next_state = START_OP;
        endcase
        // Bus error aborts whatever is in progress
        if (bus_err) begin
            next_state = START_OP;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET_CPU) begin
            state <= START_OP;
        end else begin
            state <= next_state;
        end
    end

    // ============================================================
    // Operation and extension word handshakes
    // ============================================================

    // Word stays valid until it is taken
    always_comb begin
        ow_rdy_nxt = ow_rdy;
        if (ow_take) begin
            ow_rdy_nxt = 1'b0;
        end else if (opd_ack) begin
            ow_rdy_nxt = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET_CPU) begin
            ow_rdy <= 1'b0;
            ow_req <= 1'b0;
            ew_rdy <= 1'b0;
        end else begin
            ow_rdy <= ow_rdy_nxt;
            // Ask for a new word only when START_OP holds none
            ow_req <= (next_state == START_OP) && !ow_rdy_nxt;
            // Extension word ready for the one cycle before FETCH_EXWORD is left
            ew_rdy <= (state == FETCH_EXWORD) && (next_state == FETCH_EXWORD) && ew_ack;
        end
    end

    assign ew_req = (state == FETCH_EXWORD) && !ew_rdy;

    // Absolute word address sign extended to the full bus width
    always_ff @(posedge CLK) begin
        if ((state == FETCH_EXWORD) && ew_ack) begin
            op_adr <= {{16{ext_word[15]}}, ext_word};
        end
    end

    // Operand read held until the bus master answers
    assign rd_req = (state == FETCH_OPERAND);

    // ALU starts only with a free writeback side
    assign alu_init = (state == INIT_EXEC_WB) && exec_idle;

    // Branch and trap strobes come one cycle after the opcode is taken
    always_ff @(posedge CLK) begin
        if (RESET_CPU) begin
            pc_add_displ <= 1'b0;
            ipipe_flush  <= 1'b0;
            trap_illegal <= 1'b0;
        end else begin
            pc_add_displ <= ow_take && (op == OP_BRA);
            ipipe_flush  <= ow_take && (op == OP_BRA);
            trap_illegal <= ow_take && (op == OP_ILLEGAL);
        end
    end

endmodule

//--- filelist.f
common/ctrl_pkg.sv
fetch/branch_displacement.sv
fetch/fetch_fsm.sv
exec/exec_wb_fsm.sv
verilog/data_bus_master.sv
verilog/dreg_scoreboard.sv
verilog/ctrl_top.sv
tb/ctrl_checker.sv
tb/ctrl_tb.sv

//--- tb/ctrl_checker.sv
// Bound assertions on the bus protocol, branch strobes and reset values of the controller top level
`timescale 1ns/1ns

module ctrl_checker (
    input logic CLK,
    input logic RESET_CPU,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic wb_err,
    input logic ow_req,
    input logic ew_req,
    input logic alu_init,
    input logic dr_wr,
    input logic pc_add_displ,
    input logic ipipe_flush,
    input logic trap_illegal,
    input logic berr
);

    // ============================================================
    // Wishbone classic rules
    // ============================================================

    // Strobe never without an open cycle
    stb_in_cyc: assert property (@(posedge CLK) disable iff (RESET_CPU)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high while wb_cyc is low");

    // Open cycle stays until the slave answers
    cyc_held: assert property (@(posedge CLK) disable iff (RESET_CPU)
        (wb_cyc && !wb_ack && !wb_err) |=> wb_cyc)
        else $error("wb_cyc dropped before ack or err");

    // ============================================================
    // Branch and reset rules
    // ============================================================

    // Pipe flush only comes with a taken branch
    flush_with_branch: assert property (@(posedge CLK) disable iff (RESET_CPU)
        ipipe_flush |-> pc_add_displ)
        else $error("ipipe_flush without pc_add_displ");

    // All strobes and requests low in the first cycle after reset
    quiet_after_reset: assert property (@(posedge CLK)
        RESET_CPU |=> !(ow_req || ew_req || wb_cyc || wb_stb || alu_init || dr_wr ||
                        pc_add_displ || ipipe_flush || trap_illegal || berr))
        else $error("output active in the first cycle after reset");

endmodule

bind ctrl_top ctrl_checker u_checker (
    .CLK          (CLK),
    .RESET_CPU    (RESET_CPU),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .wb_err       (wb_err),
    .ow_req       (ow_req),
    .ew_req       (ew_req),
    .alu_init     (alu_init),
    .dr_wr        (dr_wr),
    .pc_add_displ (pc_add_displ),
    .ipipe_flush  (ipipe_flush),
    .trap_illegal (trap_illegal),
    .berr         (berr)
);

//--- tb/ctrl_tb.sv
// Testbench of the controller stage; runs the instruction trace with prefetch, bus and ALU models
`timescale 1ns/1ns

module ctrl_tb;
    import ctrl_pkg::*;

    localparam int    CLK_PERIOD       = 100;
    localparam string TRACE_PATH       = "tb/ctrl_trace.txt";
    localparam int    CYCLES_PER_INSTR = 64;
    localparam int    MAX_LINES        = 32;

    // Expected event kinds in the trace
    localparam int EV_NONE   = 0;
    localparam int EV_DR_WR  = 1;
    localparam int EV_BUS_RD = 2;
    localparam int EV_BUS_WR = 3;
    localparam int EV_DISPL  = 4;
    localparam int EV_TRAP   = 5;
    localparam int EV_BERR   = 6;

    logic     CLK;
    logic     RESET_CPU;
    logic     opd_ack;
    op_t      op;
    word_t    biw_0;
    word_t    biw_1;
    logic     ew_ack;
    word_t    ext_word;
    logic     wb_ack;
    logic     wb_err;
    logic     alu_bsy;
    logic     ow_req;
    logic     ew_req;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    long_t    wb_adr;
    logic     alu_init;
    op_t      op_wb;
    logic     dr_wr;
    reg_sel_t dr_sel_wr;
    long_t    displacement;
    logic     pc_add_displ;
    logic     ipipe_flush;
    logic     trap_illegal;
    logic     berr;

    // Trace contents, one entry per instruction
    logic [31:0] tr_field [MAX_LINES][9];
    int          num_lines;

    // Events still to be seen, oldest first
    int          exp_kind [$];
    logic [31:0] exp_val  [$];
    logic [31:0] exp_op   [$];

    logic [31:0] lcg_state;
    logic        resp_err;
    logic        cyc_prev;
    int          bus_wait;
    int          alu_cnt;
    int          cycle_count;
    int          timeout_limit;

    ctrl_top u_dut (
        .CLK          (CLK),
        .RESET_CPU    (RESET_CPU),
        .opd_ack      (opd_ack),
        .op           (op),
        .biw_0        (biw_0),
        .biw_1        (biw_1),
        .ew_ack       (ew_ack),
        .ext_word     (ext_word),
        .ow_req       (ow_req),
        .ew_req       (ew_req),
        .wb_ack       (wb_ack),
        .wb_err       (wb_err),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .alu_bsy      (alu_bsy),
        .alu_init     (alu_init),
        .op_wb        (op_wb),
        .dr_wr        (dr_wr),
        .dr_sel_wr    (dr_sel_wr),
        .displacement (displacement),
        .pc_add_displ (pc_add_displ),
        .ipipe_flush  (ipipe_flush),
        .trap_illegal (trap_illegal),
        .berr         (berr)
    );

    // ============================================================
    // Helpers
    // ============================================================

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // LCG returning its upper bits only
    function automatic int next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    function automatic string kind_signal(input int kind);
        case (kind)
            EV_DR_WR:            return "dr_sel_wr";
            EV_BUS_RD, EV_BUS_WR: return "wb_adr";
            EV_DISPL:            return "displacement";
            default:             return "event value";
        endcase
    endfunction

    // Compare one observed event with the oldest expected one
    task automatic observe_event(input int kind, input logic [31:0] value);
        int          k;
        logic [31:0] v;
        logic [31:0] o;
        if (exp_kind.size() == 0) begin
            fail_run($sformatf("Unexpected event of kind %0d with nothing pending", kind));
        end
        k = exp_kind.pop_front();
        v = exp_val.pop_front();
        o = exp_op.pop_front();
        if (k != kind) begin
            fail_run($sformatf("Events out of order: saw kind %0d, expected kind %0d", kind, k));
        end
        check_value(kind_signal(kind), value, v);
        if (kind == EV_DR_WR) begin
            check_value("op_wb", {29'd0, op_wb}, o);
        end
    endtask

    // ============================================================
    // Clock
    // ============================================================

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // ============================================================
    // Prefetch, extension word, ALU and Wishbone slave models
    // ============================================================

    always @(negedge CLK) begin
        if (RESET_CPU) begin
            ew_ack   = 1'b0;
            alu_bsy  = 1'b0;
            alu_cnt  = 0;
            wb_ack   = 1'b0;
            wb_err   = 1'b0;
            bus_wait = 0;
        end else begin
            // Extension word after a random delay
            ew_ack = 1'b0;
            if (ew_req && (next_random() % 2 == 0)) begin
                ew_ack = 1'b1;
            end
            // Busy starts the cycle after init
            if (alu_init) begin
                alu_cnt = next_random() % 4;
            end else if (alu_cnt > 0) begin
                alu_bsy = 1'b1;
                alu_cnt = alu_cnt - 1;
            end else begin
                alu_bsy = 1'b0;
            end
            // Single-cycle answer after random wait states
            if (wb_ack || wb_err) begin
                wb_ack   = 1'b0;
                wb_err   = 1'b0;
                bus_wait = next_random() % 3;
            end else if (wb_cyc && wb_stb) begin
                if (bus_wait > 0) begin
                    bus_wait = bus_wait - 1;
                end else if (resp_err && !wb_we) begin
                    wb_err = 1'b1;
                end else begin
                    wb_ack = 1'b1;
                end
            end
        end
    end

    // ============================================================
    // Monitor and timeout
    // ============================================================

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            fail_run($sformatf("Timeout after %0d cycles, the trace did not finish", cycle_count));
        end
        if (!RESET_CPU) begin
            if (dr_wr) begin
                observe_event(EV_DR_WR, {29'd0, dr_sel_wr});
            end
            if (wb_cyc && !cyc_prev) begin
                observe_event(wb_we ? EV_BUS_WR : EV_BUS_RD, wb_adr);
            end
            if (pc_add_displ) begin
                check_value("ipipe_flush", {31'd0, ipipe_flush}, 32'd1);
                observe_event(EV_DISPL, displacement);
            end
            if (trap_illegal) begin
                observe_event(EV_TRAP, 32'd0);
            end
            if (berr) begin
                observe_event(EV_BERR, 32'd0);
            end
        end
        cyc_prev <= wb_cyc;
    end

    // ============================================================
    // Trace reader and main sequence
    // ============================================================

    initial begin
        int          fd;
        int          code;
        int          n;
        string       line;
        logic [31:0] f [9];

        RESET_CPU     = 1'b1;
        opd_ack       = 1'b0;
        op            = OP_MOVEQ;
        biw_0         = '0;
        biw_1         = '0;
        ew_ack        = 1'b0;
        ext_word      = '0;
        wb_ack        = 1'b0;
        wb_err        = 1'b0;
        alu_bsy       = 1'b0;
        resp_err      = 1'b0;
        cyc_prev      = 1'b0;
        lcg_state     = 32'd65;
        cycle_count   = 0;
        timeout_limit = 1000;
        num_lines     = 0;

        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            fail_run("Could not open the trace file");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Skip comments and blank lines
            if (code > 0 && line.len() > 0 && line[0] != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (n == 9) begin
                    if (num_lines == MAX_LINES) begin
                        fail_run("Trace file holds too many lines");
                    end
                    for (int j = 0; j < 9; j++) begin
                        tr_field[num_lines][j] = f[j];
                    end
                    num_lines = num_lines + 1;
                end else if (n > 0) begin
                    fail_run("Malformed line in the trace file");
                end
            end
        end
        $fclose(fd);
        timeout_limit = num_lines * CYCLES_PER_INSTR + 16;

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET_CPU = 1'b0;

        for (int i = 0; i < num_lines; i++) begin
            // Present the next operation word when fetch asks
            @(negedge CLK);
            while (!ow_req) @(negedge CLK);
            op       = op_t'(tr_field[i][0][2:0]);
            biw_0    = tr_field[i][1][15:0];
            biw_1    = tr_field[i][2][15:0];
            ext_word = tr_field[i][3][15:0];
            resp_err = tr_field[i][4][0];
            opd_ack  = 1'b1;
            if (tr_field[i][5] != EV_NONE) begin
                exp_kind.push_back(int'(tr_field[i][5]));
                exp_val.push_back(tr_field[i][6]);
                exp_op.push_back(tr_field[i][0]);
            end
            if (tr_field[i][7] != EV_NONE) begin
                exp_kind.push_back(int'(tr_field[i][7]));
                exp_val.push_back(tr_field[i][8]);
                exp_op.push_back(tr_field[i][0]);
            end
            @(negedge CLK);
            opd_ack = 1'b0;
        end

        // Wait for the queue to drain and keep watching for stray events
        while (exp_kind.size() != 0) @(negedge CLK);
        repeat (8) @(negedge CLK);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- tb/ctrl_trace.txt
# op biw_0 biw_1 ext_word resp(1=err) kind1 value1 kind2 value2, all hex
# op 0 MOVEQ 1 ADD_MEM 2 MOVE_TO_MEM 3 BRA 4 ILLEGAL; kind 1 dr_wr 2 rd 3 wr 4 displ 5 trap 6 berr
0 7615 0000 0000 0 1 00000003 0 00000000
1 D478 0000 8004 0 2 FFFF8004 1 00000002
2 3BC5 0000 1200 0 3 00001200 0 00000000
1 D678 0000 0040 0 2 00000040 1 00000003
2 37C3 0000 0080 0 3 00000080 0 00000000
3 60F0 0000 0000 0 4 FFFFFFF2 0 00000000
3 6000 0100 0000 0 4 00000102 0 00000000
3 6000 FF00 0000 0 4 FFFFFF02 0 00000000
3 607E 0000 0000 0 4 00000080 0 00000000
4 4AFC 0000 0000 0 5 00000000 0 00000000
1 D278 0000 7FFE 1 2 00007FFE 6 00000000
0 7201 0000 0000 0 1 00000001 0 00000000
0 7EFF 0000 0000 0 1 00000007 0 00000000

//--- verilog/ctrl_top.sv
// Top level of the controller stage; connects fetch, execute, bus master and register scoreboard
`timescale 1ns/1ns

module ctrl_top (
    input  logic               CLK,
    input  logic               RESET_CPU,

    // Operation and extension word handshakes
    input  logic               opd_ack,
    input  ctrl_pkg::op_t      op,
    input  ctrl_pkg::word_t    biw_0,
    input  ctrl_pkg::word_t    biw_1,
    input  logic               ew_ack,
    input  ctrl_pkg::word_t    ext_word,
    output logic               ow_req,
    output logic               ew_req,

    // Wishbone classic data bus
    input  logic               wb_ack,
    input  logic               wb_err,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output ctrl_pkg::long_t    wb_adr,

    // ALU and register file control
    input  logic               alu_bsy,
    output logic               alu_init,
    output ctrl_pkg::op_t      op_wb,
    output logic               dr_wr,
    output ctrl_pkg::reg_sel_t dr_sel_wr,

    // Program flow and exceptions
    output ctrl_pkg::long_t    displacement,
    output logic               pc_add_displ,
    output logic               ipipe_flush,
    output logic               trap_illegal,
    output logic               berr
);
    import ctrl_pkg::*;

    // Operand read path from fetch
    logic     rd_req;
    logic     rd_done;
    long_t    op_adr;

    // Destination write path from exec
    logic     wr_req;
    logic     wr_done;
    long_t    wr_adr;

    // Hazard handling
    reg_sel_t dr_sel_rd;
    logic     dr_in_use;
    logic     mark_used;
    logic     exec_idle;

    // ============================================================
    // Fetch side
    // ============================================================

    fetch_fsm u_fetch (
        .CLK          (CLK),
        .RESET_CPU    (RESET_CPU),
        .opd_ack      (opd_ack),
        .op           (op),
        .biw_0        (biw_0),
        .ew_ack       (ew_ack),
        .ext_word     (ext_word),
        .rd_done      (rd_done),
        .bus_err      (berr),
        .dr_in_use    (dr_in_use),
        .exec_idle    (exec_idle),
        .ow_req       (ow_req),
        .ew_req       (ew_req),
        .rd_req       (rd_req),
        .op_adr       (op_adr),
        .dr_sel_rd    (dr_sel_rd),
        .alu_init     (alu_init),
        .pc_add_displ (pc_add_displ),
        .ipipe_flush  (ipipe_flush),
        .trap_illegal (trap_illegal)
    );

    // Displacement follows the operation words every cycle
    branch_displacement u_displ (
        .CLK          (CLK),
        .biw_0        (biw_0),
        .biw_1        (biw_1),
        .displacement (displacement)
    );

    // ============================================================
    // Execute side, bus and scoreboard
    // ============================================================

    exec_wb_fsm u_exec (
        .CLK       (CLK),
        .RESET_CPU (RESET_CPU),
        .alu_init  (alu_init),
        .op        (op),
        .biw_0     (biw_0),
        .op_adr    (op_adr),
        .alu_bsy   (alu_bsy),
        .wr_done   (wr_done),
        .bus_err   (berr),
        .exec_idle (exec_idle),
        .op_wb     (op_wb),
        .dr_sel_wr (dr_sel_wr),
        .mark_used (mark_used),
        .dr_wr     (dr_wr),
        .wr_req    (wr_req),
        .wr_adr    (wr_adr)
    );

    data_bus_master u_bus (
        .CLK       (CLK),
        .RESET_CPU (RESET_CPU),
        .rd_req    (rd_req),
        .rd_adr    (op_adr),
        .wr_req    (wr_req),
        .wr_adr    (wr_adr),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .rd_done   (rd_done),
        .wr_done   (wr_done),
        .bus_err   (berr)
    );

    dreg_scoreboard u_sb (
        .CLK       (CLK),
        .RESET_CPU (RESET_CPU),
        .mark_used (mark_used),
        .dr_wr     (dr_wr),
        .dr_sel_wr (dr_sel_wr),
        .dr_sel_rd (dr_sel_rd),
        .bus_err   (berr),
        .dr_in_use (dr_in_use)
    );

endmodule

//--- verilog/data_bus_master.sv
// Wishbone classic master for operand reads and destination writes; writes win when both are pending
`timescale 1ns/1ns

module data_bus_master (
    input  logic            CLK,
    input  logic            RESET_CPU,
    input  logic            rd_req,
    input  ctrl_pkg::long_t rd_adr,
    input  logic            wr_req,
    input  ctrl_pkg::long_t wr_adr,
    input  logic            wb_ack,
    input  logic            wb_err,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output ctrl_pkg::long_t wb_adr,
    output logic            rd_done,
    output logic            wr_done,
    output logic            bus_err
);
    import ctrl_pkg::*;

    // ============================================================
    // Cycle control
    // ============================================================

    always_ff @(posedge CLK) begin
        if (RESET_CPU) begin
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
        end else if (wb_cyc) begin
            // Running cycle ends only on the slave answer
            if (wb_ack || wb_err) begin
                wb_cyc <= 1'b0;
            end
        end else if (wr_req) begin
            // Store belongs to the older instruction
            wb_cyc <= 1'b1;
            wb_we  <= 1'b1;
        end else if (rd_req) begin
            wb_cyc <= 1'b1;
            wb_we  <= 1'b0;
        end
    end

    // Address chosen with the same priority
    always_ff @(posedge CLK) begin
        if (!wb_cyc) begin
            wb_adr <= wr_req ? wr_adr : rd_adr;
        end
    end

    // Strobe follows cycle for a single transfer per cycle
    assign wb_stb = wb_cyc;

    // Error takes precedence over ack in the completion pulses
    assign rd_done = wb_cyc && !wb_we && wb_ack && !wb_err;
    assign wr_done = wb_cyc && wb_we && wb_ack && !wb_err;
    assign bus_err = wb_cyc && wb_err;

endmodule

//--- verilog/dreg_scoreboard.sv
// In-use flags of the data registers; stalls fetch while a register waits for writeback
`timescale 1ns/1ns

module dreg_scoreboard (
    input  logic               CLK,
    input  logic               RESET_CPU,
    input  logic               mark_used,
    input  logic               dr_wr,
    input  ctrl_pkg::reg_sel_t dr_sel_wr,
    input  ctrl_pkg::reg_sel_t dr_sel_rd,
    input  logic               bus_err,
    output logic               dr_in_use
);
    import ctrl_pkg::*;

    logic [NUM_DREGS-1:0] in_use;

    always_ff @(posedge CLK) begin
        if (RESET_CPU || bus_err) begin
            // Aborted instructions leave no pending writeback
            in_use <= '0;
        end else begin
            if (dr_wr) begin
                in_use[dr_sel_wr] <= 1'b0;
            end
            // Set comes last so it wins over a clear
            if (mark_used) begin
                in_use[dr_sel_wr] <= 1'b1;
            end
        end
    end

    assign dr_in_use = in_use[dr_sel_rd];

endmodule
